/* rtl/rv_pkg.sv */
//--------------------------------------------------------------------------
// shared widths, opcodes and instruction word views for the rv core slice
// every module pulls these in with a wildcard import of rv_pkg
//--------------------------------------------------------------------------
package rv_pkg;

    // sizes ------------------------------------------------------------------
    localparam int XLEN       = 32;                // data path width
    localparam int REG_ADDR_W = 5;                 // register index width
    localparam int IPB_DEPTH  = 4;                 // prefetch entries, power of two
    localparam int IPB_PTR_W  = $clog2(IPB_DEPTH); // prefetch pointer width

    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0100; // first fetch address

    // major opcodes ----------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011; // reg-reg alu ops
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // reg-imm alu ops

    // funct3 codes
    localparam logic [2:0] F3_ADD  = 3'b000; // add / sub
    localparam logic [2:0] F3_SLL  = 3'b001; // shift left
    localparam logic [2:0] F3_SLT  = 3'b010; // signed less-than
    localparam logic [2:0] F3_SLTU = 3'b011; // unsigned less-than
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // picks sub and sra

    // one instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;                                    // register-register view
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;                                    // register-immediate view
    } instr_u;

endpackage

/* rtl/rv_fetch.sv */
//--------------------------------------------------------------------------
// instruction fetch engine, one read on the instruction bus at a time
// only requests when the prefetch buffer has room for the answer
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rv_fetch
    import rv_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [XLEN-1:0]     i_bus_rdata_i, // fetched word
    input  logic                i_bus_ack_i,   // read done, data valid
    input  logic [IPB_PTR_W:0]  free_i,        // empty buffer slots
    output logic [XLEN-1:0]     i_bus_addr_o,  // held until ack
    output logic                i_bus_re_o,    // one-cycle read pulse
    output logic                fetch_we_o,    // push into buffer
    output logic [XLEN-1:0]     fetch_word_o,
    output logic [XLEN-1:0]     fetch_pc_o
);

    logic [XLEN-1:0]    pc_q;   // address of current / next read
    logic               pend_q; // read in flight
    logic               re_q;
    logic               done;   // in-flight read answered now
    logic               busy;   // in-flight read still waiting
    logic [IPB_PTR_W:0] space;  // room left after this cycle's push
    logic               issue;

    assign done  = pend_q & i_bus_ack_i;
    assign busy  = pend_q & ~i_bus_ack_i;
    assign space = free_i - {{IPB_PTR_W{1'b0}}, done}; // reserve slot for answer
    assign issue = ~busy & (space != '0);

    // request control --------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q   <= BOOT_ADDR;
            pend_q <= 1'b0;
            re_q   <= 1'b0;
        end else begin
            re_q   <= issue;         // back-to-back after ack if room
            pend_q <= issue | busy;
            if (done) begin
                pc_q <= pc_q + 32'd4; // sequential only
            end
        end
    end

    assign i_bus_addr_o = pc_q;
    assign i_bus_re_o   = re_q;

    // answer goes straight to the buffer, tagged with its pc
    assign fetch_we_o   = done;
    assign fetch_word_o = i_bus_rdata_i;
    assign fetch_pc_o   = pc_q;

endmodule

/* rtl/rv_ipb.sv */
//--------------------------------------------------------------------------
// instruction prefetch buffer, circular FIFO of words and their pcs
// head entry is shown combinationally, push and pop may share a cycle
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rv_ipb
    import rv_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               push_i,      // caller guarantees room
    input  logic [XLEN-1:0]    push_word_i,
    input  logic [XLEN-1:0]    push_pc_i,
    input  logic               pop_i,
    output logic               avail_o,     // not empty
    output logic [XLEN-1:0]    word_o,      // head word
    output logic [XLEN-1:0]    pc_o,        // head pc
    output logic [IPB_PTR_W:0] free_o       // empty slots
);

    logic [XLEN-1:0]      word_mem [IPB_DEPTH];
    logic [XLEN-1:0]      pc_mem   [IPB_DEPTH];
    logic [IPB_PTR_W-1:0] wr_ptr;
    logic [IPB_PTR_W-1:0] rd_ptr;
    logic [IPB_PTR_W:0]   count;  // occupancy
    logic                 do_pop;

    assign avail_o = (count != '0);
    assign do_pop  = pop_i & avail_o; // ignore pop when empty
    assign word_o  = word_mem[rd_ptr];
    assign pc_o    = pc_mem[rd_ptr];
    assign free_o  = (IPB_PTR_W+1)'(IPB_DEPTH) - count;

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            word_mem[wr_ptr] <= push_word_i;
            pc_mem[wr_ptr]   <= push_pc_i;
        end
    end

    // pointers and count -----------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2^n
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

/* rtl/rv_regfile.sv */
//--------------------------------------------------------------------------
// integer register file, 32 x XLEN, two async read ports, one write port
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (we_i && (waddr_i != '0)) begin // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 forced to zero on read
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* rtl/rv_exec.sv */
//--------------------------------------------------------------------------
// execute stage, pops the buffer head, runs the rv32i alu ops, writes back
// retirement shows on the wb trace port for one cycle, halt stops popping
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rv_exec
    import rv_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  db_halt_req_i,
    input  logic                  avail_i,    // buffer not empty
    input  logic [XLEN-1:0]       word_i,     // head instruction
    input  logic [XLEN-1:0]       pc_i,       // head pc
    output logic                  pop_o,
    output logic                  debug_o,    // halted
    output logic                  wb_valid_o, // retire strobe
    output logic                  wb_we_o,    // retire wrote a register
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [XLEN-1:0]       wb_pc_o
);

    instr_u                ir;
    logic                  is_op;    // reg-reg
    logic                  is_imm;   // reg-imm
    logic                  alt;      // sub / sra
    logic                  wr_en;
    logic                  do_pop;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm_sext;
    logic [XLEN-1:0]       opb;      // second alu operand
    logic [4:0]            shamt;
    logic [XLEN-1:0]       sra_res;
    logic [XLEN-1:0]       res;

    // decode -----------------------------------------------------------------
    assign ir       = word_i;
    assign is_op    = (ir.r.opcode == OPC_OP);
    assign is_imm   = (ir.i.opcode == OPC_OP_IMM);
    assign rd       = ir.r.rd;                                     // same slot in both views
    assign imm_sext = {{(XLEN-12){ir.i.imm12[11]}}, ir.i.imm12};
    assign opb      = is_op ? rs2_val : imm_sext;
    assign shamt    = opb[4:0];                                   // low 5 bits only
    assign alt      = is_op ? (ir.r.funct7 == F7_ALT) : (ir.i.imm12[11:5] == F7_ALT);
    assign wr_en    = (is_op | is_imm) & (rd != '0);              // unsupported or x0 -> no write
    assign do_pop   = avail_i & ~debug_o;
    assign pop_o    = do_pop;

    rv_regfile u_regfile (
        .clk_i    (clk_i),
        .we_i     (do_pop & wr_en),
        .waddr_i  (rd),
        .wdata_i  (res),
        .raddr1_i (ir.r.rs1),
        .raddr2_i (ir.r.rs2),  // don't care for imm ops
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val)
    );

    // alu --------------------------------------------------------------------
    assign sra_res = $signed(rs1_val) >>> shamt; // kept apart to stay signed

    always_comb begin
        case (ir.r.funct3)
            F3_ADD:  res = (is_op && alt) ? (rs1_val - opb) : (rs1_val + opb); // addi never subs
            F3_SLL:  res = rs1_val << shamt;
            F3_SLT:  res = {{(XLEN-1){1'b0}}, ($signed(rs1_val) < $signed(opb))};
            F3_SLTU: res = {{(XLEN-1){1'b0}}, (rs1_val < opb)};
            F3_XOR:  res = rs1_val ^ opb;
            F3_SR:   res = alt ? sra_res : (rs1_val >> shamt);
            F3_OR:   res = rs1_val | opb;
            default: res = rs1_val & opb; // F3_AND
        endcase
    end

    // halt and retire strobes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            debug_o    <= 1'b0;
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            debug_o    <= db_halt_req_i;   // one cycle late
            wb_valid_o <= do_pop;
            wb_we_o    <= do_pop & wr_en;
        end
    end

    // trace payload, only meaningful with wb_valid_o
    always_ff @(posedge clk_i) begin
        if (do_pop) begin
            wb_rd_o   <= rd;
            wb_data_o <= res;
            wb_pc_o   <= pc_i;
        end
    end

endmodule

/* rtl/rv_core.sv */
//--------------------------------------------------------------------------
// core top, fetch -> prefetch buffer -> execute, bus and trace to outside
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module rv_core
    import rv_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [XLEN-1:0]       i_bus_rdata_i,
    input  logic                  i_bus_ack_i,
    input  logic                  db_halt_req_i,
    output logic [XLEN-1:0]       i_bus_addr_o,
    output logic                  i_bus_re_o,
    output logic                  debug_o,
    output logic                  wb_valid_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [XLEN-1:0]       wb_pc_o
);

    logic [IPB_PTR_W:0] ipb_free;   // buffer room back to fetch
    logic               fetch_we;
    logic [XLEN-1:0]    fetch_word;
    logic [XLEN-1:0]    fetch_pc;
    logic               ipb_avail;
    logic [XLEN-1:0]    ipb_word;   // head to execute
    logic [XLEN-1:0]    ipb_pc;
    logic               exec_pop;

    // fetch ------------------------------------------------------------------
    rv_fetch u_fetch (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .i_bus_rdata_i (i_bus_rdata_i),
        .i_bus_ack_i   (i_bus_ack_i),
        .free_i        (ipb_free),
        .i_bus_addr_o  (i_bus_addr_o),
        .i_bus_re_o    (i_bus_re_o),
        .fetch_we_o    (fetch_we),
        .fetch_word_o  (fetch_word),
        .fetch_pc_o    (fetch_pc)
    );

    rv_ipb u_ipb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (fetch_we),
        .push_word_i (fetch_word),
        .push_pc_i   (fetch_pc),
        .pop_i       (exec_pop),
        .avail_o     (ipb_avail),
        .word_o      (ipb_word),
        .pc_o        (ipb_pc),
        .free_o      (ipb_free)
    );

    // execute ----------------------------------------------------------------
    rv_exec u_exec (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .db_halt_req_i (db_halt_req_i),
        .avail_i       (ipb_avail),
        .word_i        (ipb_word),
        .pc_i          (ipb_pc),
        .pop_o         (exec_pop),
        .debug_o       (debug_o),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_pc_o       (wb_pc_o)
    );

endmodule

/* testbench/tb_rv_model.sv */
//--------------------------------------------------------------------------
// reference model for the core testbench, register copy and alu rules
// also makes the random rv32i alu instruction words for the bus memory
//--------------------------------------------------------------------------
package tb_rv_model;
    import rv_pkg::*;

    // run sizes --------------------------------------------------------------
    localparam int MEM_WORDS = 512;   // instruction memory depth
    localparam int N_RETIRE  = 300;   // retirements before the run ends
    localparam int N_PRELOAD = 31;    // x1..x31 set up front
    localparam int RUN_LIMIT = 20000; // cycles for the whole run
    localparam int REQ_LIMIT = 500;   // cycles without a bus request

    logic [XLEN-1:0] model_regs [32]; // architectural register copy

    function automatic void model_init();
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
    endfunction

    // memory word index of a fetch address
    function automatic int mem_index(input logic [XLEN-1:0] addr);
        return int'((addr - BOOT_ADDR) >> 2);
    endfunction

    // uniform pick in lo..hi
    function automatic int rand_between(inout int seed, input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // addi rd, x0, random imm, gives every register a known value
    function automatic logic [31:0] gen_init_instr(input logic [4:0] rd, inout int seed);
        logic [31:0] r;
        r = $random(seed);
        return {r[11:0], 5'd0, F3_ADD, rd, OPC_OP_IMM};
    endfunction

    // random alu word, sometimes rd = x0, sometimes a foreign opcode
    function automatic logic [31:0] gen_instr(inout int seed);
        logic [31:0] r;    // class and variant bits
        logic [31:0] f;    // field bits
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        r   = $random(seed);
        f   = $random(seed);
        rd  = f[11:7];
        f3  = f[14:12];
        alt = r[4];                                 // sub / sra where legal
        if (r[3:0] == 4'd0) begin
            opc = r[10:4];
            if ((opc == OPC_OP) || (opc == OPC_OP_IMM)) begin
                opc = opc ^ 7'h40;                  // push it off the alu opcodes
            end
            return {f[31:7], opc};
        end
        if (r[3:0] == 4'd1) begin
            rd = 5'd0;                              // result thrown away
        end
        if (r[5]) begin
            f7 = (alt && ((f3 == F3_ADD) || (f3 == F3_SR))) ? F7_ALT : 7'd0;
            return {f7, f[24:15], f3, rd, OPC_OP};
        end
        imm = f[31:20];
        if (f3 == F3_SLL) begin
            imm[11:5] = 7'd0;                       // slli, shamt only
        end else if (f3 == F3_SR) begin
            imm[11:5] = alt ? F7_ALT : 7'd0;        // srai or srli
        end
        return {imm, f[19:15], f3, rd, OPC_OP_IMM};
    endfunction

    // retire one word on the model, gives the expected trace fields
    function automatic void model_exec(input logic [31:0] w, output logic we,
                                       output logic [4:0] rd, output logic [31:0] data);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        upper;  // funct7 asks for sub / sra
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        opc   = w[6:0];
        rd    = w[11:7];
        f3    = w[14:12];
        upper = (w[31:25] == F7_ALT);
        a     = model_regs[w[19:15]];
        if (opc == OPC_OP) begin
            b = model_regs[w[24:20]];
        end else begin
            b = {{20{w[31]}}, w[31:20]};            // sign-extended imm
        end
        sh = b[4:0];
        case (f3)
            F3_ADD:  data = ((opc == OPC_OP) && upper) ? (a - b) : (a + b);
            F3_SLL:  data = a << sh;
            F3_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: data = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  data = a ^ b;
            F3_SR: begin
                data = a >> sh;
                if (upper && a[31]) begin
                    data = data | ~(32'hFFFF_FFFF >> sh); // fill with sign
                end
            end
            F3_OR:   data = a | b;
            default: data = a & b;
        endcase
        we = ((opc == OPC_OP) || (opc == OPC_OP_IMM)) && (rd != 5'd0);
        if (we) begin
            model_regs[rd] = data;
        end
    endfunction

endpackage

/* testbench/tb_rv_core.sv */
//--------------------------------------------------------------------------
// testbench for the core slice with a random alu program in a bus memory
// checks bus order, halt back-pressure and every retirement vs the model
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_rv_core
    import rv_pkg::*, tb_rv_model::*;
();

    logic                  clk_i;
    logic                  rst_n_i;
    logic [XLEN-1:0]       i_bus_rdata_i;
    logic                  i_bus_ack_i;
    logic                  db_halt_req_i;
    logic [XLEN-1:0]       i_bus_addr_o;
    logic                  i_bus_re_o;
    logic                  debug_o;
    logic                  wb_valid_o;
    logic                  wb_we_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic [XLEN-1:0]       wb_pc_o;

    logic [XLEN-1:0] imem [MEM_WORDS];   // program seen by the bus
    int              seed;
    int              retired;             // wb_valid_o strobes so far
    int              acks;                // bus answers so far
    logic [XLEN-1:0] exp_req_addr;        // next request address
    logic [XLEN-1:0] exp_pc;              // next retiring pc
    logic [XLEN-1:0] open_addr;           // address of read in flight
    logic            req_open;
    logic            halt_req_q;          // db_halt_req_i one cycle back
    logic            halt_seen;           // expected debug_o one cycle back

    rv_core uut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .i_bus_rdata_i (i_bus_rdata_i),
        .i_bus_ack_i   (i_bus_ack_i),
        .db_halt_req_i (db_halt_req_i),
        .i_bus_addr_o  (i_bus_addr_o),
        .i_bus_re_o    (i_bus_re_o),
        .debug_o       (debug_o),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_pc_o       (wb_pc_o)
    );

    // error reporting --------------------------------------------------------
    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_hang(input string what);
        $display("timeout while %s", what);
        $display("Result: FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_quiet(input string phase);
        assert (!i_bus_re_o && !wb_valid_o && !wb_we_o && !debug_o) else
            report_mismatch($sformatf("strobes not idle %s", phase));
    endtask

    // 20 ns clock
    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    // main sequence ----------------------------------------------------------
    initial begin : main_seq
        int waited;
        rst_n_i       = 1'b0;
        i_bus_rdata_i = '0;
        i_bus_ack_i   = 1'b0;
        db_halt_req_i = 1'b0;
        seed          = 86;
        retired       = 0;
        acks          = 0;
        exp_req_addr  = BOOT_ADDR;
        exp_pc        = BOOT_ADDR;
        open_addr     = '0;
        req_open      = 1'b0;
        halt_req_q    = 1'b0;
        halt_seen     = 1'b0;
        model_init();
        for (int k = 0; k < MEM_WORDS; k++) begin
            if (k < N_PRELOAD) begin
                imem[k] = gen_init_instr(5'(k + 1), seed); // x1..x31 first
            end else begin
                imem[k] = gen_instr(seed);
            end
        end
        @(posedge clk_i);
        @(negedge clk_i);
        check_quiet("during reset");
        @(posedge clk_i);
        rst_n_i <= 1'b1;                                   // 2 edges in reset
        @(negedge clk_i);
        check_quiet("in first cycle after reset");
        assert (i_bus_addr_o == BOOT_ADDR) else
            report_mismatch($sformatf("fetch address %h after reset", i_bus_addr_o));
        waited = 0;
        while (retired < N_RETIRE) begin
            @(posedge clk_i);
            waited++;
            if (waited > RUN_LIMIT) begin
                report_hang("waiting for all retirements");
            end
        end
        $display("Result: PASSED");
        $finish;
    end

    // bus memory answers each request after 1 to 4 cycles
    initial begin : mem_responder
        int              lat;
        int              idle;
        int              idx;
        logic [XLEN-1:0] addr;
        forever begin
            idle = 0;
            @(negedge clk_i);
            while (!(rst_n_i && i_bus_re_o)) begin
                idle++;
                if (idle > REQ_LIMIT) begin
                    report_hang("waiting for an instruction bus request");
                end
                @(negedge clk_i);
            end
            addr = i_bus_addr_o;
            idx  = mem_index(addr);
            assert ((idx >= 0) && (idx < MEM_WORDS)) else
                report_mismatch($sformatf("request address %h outside memory", addr));
            lat = rand_between(seed, 1, 4);
            repeat (lat) @(posedge clk_i);
            i_bus_ack_i   <= 1'b1;
            i_bus_rdata_i <= imem[idx];
            @(posedge clk_i);
            i_bus_ack_i   <= 1'b0;
        end
    end

    // halt stretches long enough to fill the buffer
    initial begin : halt_driver
        int gap;
        int len;
        @(posedge clk_i);                                  // program built by now
        forever begin
            gap = rand_between(seed, 10, 60);
            len = rand_between(seed, 1, 30);
            repeat (gap) @(posedge clk_i);
            db_halt_req_i <= 1'b1;
            repeat (len) @(posedge clk_i);
            db_halt_req_i <= 1'b0;
        end
    end

    // bus and trace checks sampled mid-cycle ---------------------------------
    always @(negedge clk_i) begin : trace_monitor
        logic            exp_we;
        logic [4:0]      exp_rd;
        logic [XLEN-1:0] exp_data;
        logic [XLEN-1:0] w;
        if (rst_n_i) begin
            if (i_bus_re_o) begin
                assert (!req_open) else
                    report_mismatch("new bus read while one is outstanding");
                assert (i_bus_addr_o == exp_req_addr) else
                    report_mismatch($sformatf("request address %h, expected %h",
                                              i_bus_addr_o, exp_req_addr));
                req_open     = 1'b1;
                open_addr    = i_bus_addr_o;
                exp_req_addr = exp_req_addr + 32'd4;       // strictly sequential
            end else if (req_open) begin
                assert (i_bus_addr_o == open_addr) else
                    report_mismatch($sformatf("address moved to %h before ack",
                                              i_bus_addr_o));
            end
            if (i_bus_ack_i) begin
                req_open = 1'b0;
                acks++;
            end
            assert (debug_o == halt_req_q) else
                report_mismatch($sformatf("debug_o %b, expected %b",
                                          debug_o, halt_req_q));
            assert (!(wb_valid_o && halt_seen)) else
                report_mismatch("retirement while halted");
            if (wb_valid_o) begin
                w = imem[mem_index(exp_pc)];
                model_exec(w, exp_we, exp_rd, exp_data);
                assert (wb_pc_o == exp_pc) else
                    report_mismatch($sformatf("retired pc %h, expected %h", wb_pc_o, exp_pc));
                assert (wb_we_o == exp_we) else
                    report_mismatch($sformatf("pc %h word %h write flag %b, expected %b",
                                              exp_pc, w, wb_we_o, exp_we));
                assert (wb_rd_o == exp_rd) else
                    report_mismatch($sformatf("pc %h rd %0d, expected %0d",
                                              exp_pc, wb_rd_o, exp_rd));
                if (exp_we) begin
                    assert (wb_data_o == exp_data) else
                        report_mismatch($sformatf("pc %h word %h data %h, expected %h",
                                                  exp_pc, w, wb_data_o, exp_data));
                end
                exp_pc = exp_pc + 32'd4;
                retired++;
            end else begin
                assert (!wb_we_o) else
                    report_mismatch("register write strobe without retirement");
            end
            assert ((acks - retired) <= IPB_DEPTH) else
                report_mismatch($sformatf("%0d words in flight past the buffer",
                                          acks - retired));
            halt_seen  = halt_req_q;                        // gates next retirement
            halt_req_q = db_halt_req_i;
        end
    end

endmodule

/* rv_core.f */
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_ipb.sv
rtl/rv_regfile.sv
rtl/rv_exec.sv
rtl/rv_core.sv
testbench/tb_rv_model.sv
testbench/tb_rv_core.sv
